// ==== filelist.f ====
+incdir+.
armCtl_pkg.sv
instrDecoder.sv
opQueue.sv
dpAlu.sv
opExecutor.sv
armCtl.sv
armCtl_chk.sv
armCtl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the armCtl testbench with Verilator.
# Exits 0 only when the pass message shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module armCtl_tb -Mdir obj_dir -o armCtl_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/armCtl_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1

// ==== armCtl_tb.sv ====
/*
	Testbench for the execute-control core.
	Sends ARM words over the four-phase handshake, predicts each retire
	event with a reference model, and compares at every retire pulse.
	Run through run.sh; the last line gives the overall verdict.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module armCtl_tb import armCtl_pkg::*; ();

	localparam logic [31:0] SEED = 32'h8e05_6ef0;
	localparam int N_IMM = 16;
	localparam int N_LOGIC = 16;
	localparam int N_COND = 12; // compare plus conditional add
	localparam int N_BRANCH = 10; // compare plus branch
	localparam int N_STREAM = 24;
	localparam int N_DROP = 8;
	localparam int TOTAL_INSTR = N_IMM + N_LOGIC + 2 * N_COND + 2 * N_BRANCH + N_STREAM + N_DROP;
	localparam int CYCLE_LIMIT = 40 * TOTAL_INSTR + 200;
	localparam aluOp_e LOGIC_OPS [6] = '{ALU_AND, ALU_EOR, ALU_ORR, ALU_BIC, ALU_MVN, ALU_RSB};
	localparam aluOp_e DROPPED_OPS [4] = '{ALU_ADC, ALU_SBC, ALU_RSC, ALU_CMN};

	typedef struct packed {
		logic wr;
		logic [`REG_ADDR_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] data;
		logic br;
		logic [`DATA_WIDTH-1:0] target;
		logic [`FLAG_WIDTH-1:0] flags;
	} retireEvt_t;

	logic clk, reset, instrReq, instrAck, retire, regWrite, branchTaken;
	logic [`DATA_WIDTH-1:0] instr, instrPc, regWriteData, branchTarget;
	logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
	logic [`FLAG_WIDTH-1:0] flags;

	retireEvt_t expQ[$]; // predicted events, oldest first
	logic [`DATA_WIDTH-1:0] mRegs [`REG_COUNT];
	logic [`FLAG_WIDTH-1:0] mFlags;
	logic [31:0] rngState, nextPc;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int errMark = 0;

	armCtl u_armCtl (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d instructions never retired", cycles, expQ.size());
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic logic [31:0] dpImmWord(input logic [3:0] cond, input aluOp_e op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] imm12);
		return {cond, 3'b001, op, s, rn, rd, imm12};
	endfunction

	// unshifted register operand, shift field left zero
	function automatic logic [31:0] dpRegWord(input logic [3:0] cond, input aluOp_e op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
		return {cond, 3'b000, op, s, rn, rd, 8'h00, rm};
	endfunction

	// reference model, advances mRegs and mFlags
	function automatic retireEvt_t expectRetire(input logic [31:0] w, input logic [31:0] pc);
		retireEvt_t e;
		aluOp_e op;
		logic [31:0] a, b, r;
		logic [32:0] wide;
		logic [4:0] rot;
		logic n, z, c, v, pass, arith, known, writes, cOut, vOut;
		e = '0;
		{n, z, c, v} = mFlags;
		case (w[31:28])
			4'h0: pass = z;
			4'h1: pass = !z;
			4'h2: pass = c;
			4'h3: pass = !c;
			4'h4: pass = n;
			4'h5: pass = !n;
			4'h6: pass = v;
			4'h7: pass = !v;
			4'h8: pass = c && !z;
			4'h9: pass = !c || z;
			4'hA: pass = (n == v);
			4'hB: pass = (n != v);
			4'hC: pass = !z && (n == v);
			4'hD: pass = z || (n != v);
			default: pass = 1'b1; // AL and 1111
		endcase
		op = aluOp_e'(w[24:21]);
		{r, wide, cOut, vOut, arith} = '0;
		known = 1'b1;
		writes = 1'b1;
		if (pass && w[27:25] == 3'b101) begin
			e.br = 1'b1;
			e.target = pc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
			e.wr = w[24];
			e.addr = 4'(`LINK_REG);
			e.data = pc + 32'd4;
		end else if (pass && w[27:26] == 2'b00) begin
			rot = {w[11:8], 1'b0};
			a = mRegs[w[19:16]];
			b = {24'b0, w[7:0]};
			b = w[25] ? (b >> rot) | (b << (6'd32 - {1'b0, rot})) : mRegs[w[3:0]];
			case (op)
				ALU_AND: r = a & b;
				ALU_EOR: r = a ^ b;
				ALU_ORR: r = a | b;
				ALU_BIC: r = a & ~b;
				ALU_MOV: r = b;
				ALU_MVN: r = ~b;
				ALU_TST: {r, writes} = {a & b, 1'b0};
				ALU_TEQ: {r, writes} = {a ^ b, 1'b0};
				ALU_ADD: begin
					wide = {1'b0, a} + {1'b0, b};
					{arith, cOut, vOut} = {1'b1, wide[32], (a[31] == b[31]) && (wide[31] != a[31])};
				end
				ALU_SUB, ALU_CMP: begin
					wide = {1'b0, a} - {1'b0, b};
					{arith, cOut, vOut} = {1'b1, a >= b, (a[31] != b[31]) && (wide[31] != a[31])};
					writes = (op != ALU_CMP);
				end
				ALU_RSB: begin
					wide = {1'b0, b} - {1'b0, a};
					{arith, cOut, vOut} = {1'b1, b >= a, (a[31] != b[31]) && (wide[31] != b[31])};
				end
				default: {known, writes} = 2'b00; // ADC SBC RSC CMN
			endcase
			if (arith)
				r = wide[31:0];
			{e.wr, e.addr, e.data} = {writes, w[15:12], r};
			if (known && (w[20] || op inside {ALU_TST, ALU_TEQ, ALU_CMP})) begin
				{n, z} = {r[31], r == 32'd0};
				if (arith)
					{c, v} = {cOut, vOut};
			end
		end
		if (e.wr)
			mRegs[e.addr] = e.data;
		mFlags = {n, z, c, v};
		e.flags = mFlags;
		return e;
	endfunction

	task automatic sendInstr(input logic [31:0] w);
		expQ.push_back(expectRetire(w, nextPc));
		@(posedge clk);
		instrReq <= 1'b1;
		instr <= w;
		instrPc <= nextPc;
		do @(negedge clk); while (instrAck !== 1'b1);
		@(posedge clk);
		instrReq <= 1'b0;
		do @(negedge clk); while (instrAck !== 1'b0);
		nextPc = nextPc + 32'd4;
	endtask

	task automatic endTest(input string name);
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // catch stray retires
		testsRun++;
		$display("test %0d %s: %0d errors", testsRun, name, errors - errMark);
		errMark = errors;
	endtask

	always @(negedge clk) begin : compareRetire
		retireEvt_t want;
		if (!reset && retire) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("CHECK FAILED t=%0t: retire with no instruction outstanding", $time);
			end else begin
				want = expQ.pop_front();
				checks++;
				if (regWrite !== want.wr || (want.wr && (regWriteAddr !== want.addr ||
					regWriteData !== want.data))) begin
					errors++;
					$display("CHECK FAILED t=%0t: write %b r%0d=%h, expected %b r%0d=%h", $time,
						regWrite, regWriteAddr, regWriteData, want.wr, want.addr, want.data);
				end
				if (branchTaken !== want.br || (want.br && branchTarget !== want.target)) begin
					errors++;
					$display("CHECK FAILED t=%0t: branch %b to %h, expected %b to %h", $time,
						branchTaken, branchTarget, want.br, want.target);
				end
				if (flags !== want.flags) begin
					errors++;
					$display("CHECK FAILED t=%0t: flags %b, expected %b", $time, flags, want.flags);
				end
			end
		end
	end

	initial begin
		logic [31:0] r, p;
		reset = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		instrPc = '0;
		rngState = SEED;
		nextPc = 32'h0000_1000;
		mFlags = '0;
		for (int i = 0; i < `REG_COUNT; i++)
			mRegs[i] = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < N_IMM; i++) begin
			r = nextRandom();
			if (i < 8) // seed r0..r7
				sendInstr(dpImmWord(4'hE, ALU_MOV, r[31], 4'h0, 4'(i), r[11:0]));
			else
				sendInstr(dpImmWord(4'hE, r[30] ? ALU_ADD : ALU_SUB, r[31], r[19:16],
					r[23:20], r[11:0]));
		end
		endTest("immediate data processing");

		for (int i = 0; i < N_LOGIC; i++) begin
			r = nextRandom();
			sendInstr(dpRegWord(4'hE, LOGIC_OPS[int'(r[7:0]) % 6], r[8], r[19:16], r[23:20],
				r[27:24]));
		end
		endTest("register logic ops");

		for (int i = 0; i < N_COND; i++) begin
			r = nextRandom();
			sendInstr(dpRegWord(4'hE, r[0] ? ALU_CMP : ALU_TST, 1'b0, r[7:4], 4'h0,
				r[1] ? r[7:4] : r[11:8])); // same register now and then, for EQ
			sendInstr(dpImmWord(r[15:12], ALU_ADD, 1'b0, r[19:16], r[23:20], r[31:20]));
		end
		endTest("conditional execution");

		for (int i = 0; i < N_BRANCH; i++) begin
			r = nextRandom();
			p = nextRandom();
			sendInstr(dpRegWord(4'hE, ALU_CMP, 1'b1, r[3:0], 4'h0, r[7:4]));
			nextPc = {p[31:2], 2'b00};
			sendInstr({r[31:28], 3'b101, r[27], r[23:0]});
		end
		endTest("branches");

		for (int i = 0; i < N_STREAM; i++) begin
			r = nextRandom();
			case (r[1:0])
				2'd0: sendInstr(dpImmWord(r[31:28], aluOp_e'(r[24:21]), r[20], r[19:16],
					r[15:12], r[11:0]));
				2'd3: sendInstr({r[31:28], 3'b101, r[24:0]});
				default: sendInstr(dpRegWord(r[31:28], aluOp_e'(r[24:21]), r[20], r[19:16],
					r[15:12], r[7:4]));
			endcase
		end
		endTest("back-to-back stream");

		for (int i = 0; i < N_DROP; i++) begin
			r = nextRandom();
			if (i % 2 == 0)
				sendInstr({4'hE, 2'b01, r[25:0]}); // load/store class
			else
				sendInstr(dpRegWord(4'hE, DROPPED_OPS[i / 2], 1'b1, r[19:16], r[15:12], r[3:0]));
		end
		endTest("dropped classes");

		if (checks != TOTAL_INSTR)
			$display("only %0d of %0d instructions retired", checks, TOTAL_INSTR);
		$display("summary: %0d tests, %0d retires checked, %0d errors", testsRun, checks, errors);
		if (errors == 0 && checks == TOTAL_INSTR)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== armCtl_chk.sv ====
/*
	Concurrent assertions for the execute-control core.
	Bound into armCtl; watches the instruction handshake, the
	decoder-to-queue push and the retire outputs.
*/
`timescale 1ns/1ns

module armCtl_chk (
	input logic clk,
	input logic reset,
	input logic instrReq,
	input logic instrAck,
	input logic push,
	input logic full,
	input logic retire,
	input logic regWrite,
	input logic branchTaken
);

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(instrAck) |-> instrReq)
		else $error("instrAck rose while instrReq was low");

	// write and branch reports only ride on a retire pulse
	reportWithRetire: assert property (@(posedge clk) disable iff (reset)
		(regWrite || branchTaken) |-> retire)
		else $error("regWrite or branchTaken without retire");

	ackFallsAfterReq: assert property (@(posedge clk) disable iff (reset)
		$fell(instrAck) |-> !$past(instrReq))
		else $error("instrAck fell before instrReq was released");

	pushNotFull: assert property (@(posedge clk) disable iff (reset)
		push |-> !full)
		else $error("push while the queue is full");

endmodule

bind armCtl armCtl_chk u_chk (.*);

// ==== armCtl.sv ====
/*
	Top level of the execute-control core.
	Instruction words enter over a four-phase req/ack handshake, pass
	through the decoder and the operation queue, and retire in the
	executor, which reports register writes, taken branches and flags.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module armCtl import armCtl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instrReq,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic [`DATA_WIDTH-1:0]     instrPc,
	output logic                       instrAck,
	output logic                       retire,
	output logic                       regWrite,
	output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
	output logic [`DATA_WIDTH-1:0]     regWriteData,
	output logic                       branchTaken,
	output logic [`DATA_WIDTH-1:0]     branchTarget,
	output logic [`FLAG_WIDTH-1:0]     flags
);

	// decoder to queue, and queue head to executor
	logic push, full, pop, empty;
	opKind_e opKind, opKindHead;
	cond_e opCond, opCondHead;
	aluOp_e opAlu, opAluHead;
	logic opSetFlags, opSetFlagsHead;
	logic [`REG_ADDR_WIDTH-1:0] opRd, opRdHead;
	logic [`REG_ADDR_WIDTH-1:0] opRn, opRnHead;
	logic [`REG_ADDR_WIDTH-1:0] opRm, opRmHead;
	logic opImmValid, opImmValidHead;
	logic [`DATA_WIDTH-1:0] opImm, opImmHead;
	logic opLink, opLinkHead;
	logic [`DATA_WIDTH-1:0] opTarget, opTargetHead;
	logic [`DATA_WIDTH-1:0] opPc, opPcHead;

	instrDecoder u_decoder (.*);

	opQueue u_queue (.*);

	opExecutor u_executor (.*);

endmodule

// ==== opExecutor.sv ====
/*
	Executor with register file and NZCV flags.
	Pops one operation in the fetch state, checks its condition and runs
	it through the ALU in the same cycle, and presents the retire pulse
	with its register write, branch report and updated flags one cycle
	after the pop. A failed condition retires with nothing written.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module opExecutor import armCtl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       empty,
	output logic                       pop,
	input  opKind_e                    opKindHead,
	input  cond_e                      opCondHead,
	input  aluOp_e                     opAluHead,
	input  logic                       opSetFlagsHead,
	input  logic [`REG_ADDR_WIDTH-1:0] opRdHead,
	input  logic [`REG_ADDR_WIDTH-1:0] opRnHead,
	input  logic [`REG_ADDR_WIDTH-1:0] opRmHead,
	input  logic                       opImmValidHead,
	input  logic [`DATA_WIDTH-1:0]     opImmHead,
	input  logic                       opLinkHead,
	input  logic [`DATA_WIDTH-1:0]     opTargetHead,
	input  logic [`DATA_WIDTH-1:0]     opPcHead,
	output logic                       retire,
	output logic                       regWrite,
	output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
	output logic [`DATA_WIDTH-1:0]     regWriteData,
	output logic                       branchTaken,
	output logic [`DATA_WIDTH-1:0]     branchTarget,
	output logic [`FLAG_WIDTH-1:0]     flags
);

	typedef enum logic {
		EX_FETCH,
		EX_EXEC
	} exState_e;

	exState_e state;
	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
	logic [`FLAG_WIDTH-1:0] flagsReg, aluFlags;
	logic [`DATA_WIDTH-1:0] opA, opB, aluResult;
	logic aluWrites, condPass, flagsUpdate;
	logic wrEn, brTaken;
	logic [`REG_ADDR_WIDTH-1:0] wrAddr;
	logic [`DATA_WIDTH-1:0] wrData;

	function automatic logic checkCond(input cond_e cond, input logic [`FLAG_WIDTH-1:0] f);
		logic n, z, c, v;
		n = f[`FLAG_N];
		z = f[`FLAG_Z];
		c = f[`FLAG_C];
		v = f[`FLAG_V];
		case (cond)
			COND_EQ: checkCond = z;
			COND_NE: checkCond = !z;
			COND_CS: checkCond = c;
			COND_CC: checkCond = !c;
			COND_MI: checkCond = n;
			COND_PL: checkCond = !n;
			COND_VS: checkCond = v;
			COND_VC: checkCond = !v;
			COND_HI: checkCond = c && !z;
			COND_LS: checkCond = !c || z;
			COND_GE: checkCond = (n == v);
			COND_LT: checkCond = (n != v);
			COND_GT: checkCond = !z && (n == v);
			COND_LE: checkCond = z || (n != v);
			default: checkCond = 1'b1; // AL, and NV taken as always
		endcase
	endfunction

	assign pop = (state == EX_FETCH) && !empty; // at most one pop every two cycles
	assign opA = regFile[opRnHead];
	assign opB = opImmValidHead ? opImmHead : regFile[opRmHead];
	assign condPass = checkCond(opCondHead, flagsReg);
	assign flags = flagsReg;

	dpAlu u_alu (
		.aluOp        (opAluHead),
		.a            (opA),
		.b            (opB),
		.flagsIn      (flagsReg),
		.result       (aluResult),
		.flagsOut     (aluFlags),
		.writesResult (aluWrites)
	);

	always_comb begin
		wrEn = 1'b0;
		wrAddr = opRdHead;
		wrData = aluResult;
		brTaken = 1'b0;
		flagsUpdate = 1'b0;
		if (condPass) begin
			case (opKindHead)
				DATA_PROC: begin
					wrEn = aluWrites;
					// compares set flags whatever the S bit says
					flagsUpdate = opSetFlagsHead || (opAluHead inside {ALU_TST, ALU_TEQ, ALU_CMP});
				end
				BRANCH: begin
					brTaken = 1'b1;
					wrEn = opLinkHead; // BL only
					wrAddr = `REG_ADDR_WIDTH'(`LINK_REG);
					wrData = opPcHead + `DATA_WIDTH'(4);
				end
				default: ; // NOP retires silently
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EX_FETCH;
			retire <= 1'b0;
			regWrite <= 1'b0;
			branchTaken <= 1'b0;
			flagsReg <= '0;
			for (int i = 0; i < `REG_COUNT; i++)
				regFile[i] <= '0;
		end else begin
			state <= pop ? EX_EXEC : EX_FETCH;
			retire <= pop;
			regWrite <= pop && wrEn;
			branchTaken <= pop && brTaken;
			if (pop && wrEn)
				regFile[wrAddr] <= wrData;
			if (pop && flagsUpdate)
				flagsReg <= aluFlags; // visible on flags during the retire cycle
		end
	end

	// retire payload, qualified by regWrite and branchTaken
	always_ff @(posedge clk) begin
		if (pop) begin
			regWriteAddr <= wrAddr;
			regWriteData <= wrData;
			branchTarget <= opTargetHead;
		end
	end

endmodule

// ==== dpAlu.sv ====
/*
	Data-processing ALU, purely combinational.
	One shared adder serves ADD, SUB, RSB and CMP. Logic ops and moves
	update only N and Z; arithmetic updates all of NZCV, with C meaning
	no borrow on subtraction. ADC, SBC, RSC and CMN write nothing and
	pass the flags through.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module dpAlu import armCtl_pkg::*; (
	input  aluOp_e                 aluOp,
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  logic [`FLAG_WIDTH-1:0] flagsIn,
	output logic [`DATA_WIDTH-1:0] result,
	output logic [`FLAG_WIDTH-1:0] flagsOut,
	output logic                   writesResult
);

	localparam int MSB = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH-1:0] addX, addY;
	logic addCin;
	logic [`DATA_WIDTH:0] addSum;
	logic carry, overflow;
	logic isArith, isLogic;

	// subtract is the default setup, x + ~y + 1
	always_comb begin
		addX = a;
		addY = ~b;
		addCin = 1'b1;
		if (aluOp == ALU_ADD) begin
			addY = b;
			addCin = 1'b0;
		end else if (aluOp == ALU_RSB) begin
			addX = b;
			addY = ~a;
		end
	end

	assign addSum = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addCin};
	assign carry = addSum[`DATA_WIDTH];
	assign overflow = (addX[MSB] == addY[MSB]) && (addSum[MSB] != addX[MSB]);

	always_comb begin
		result = '0;
		isArith = 1'b0;
		isLogic = 1'b1;
		writesResult = 1'b1;
		case (aluOp)
			ALU_AND: result = a & b;
			ALU_EOR: result = a ^ b;
			ALU_ORR: result = a | b;
			ALU_BIC: result = a & ~b;
			ALU_MOV: result = b;
			ALU_MVN: result = ~b;
			ALU_TST: begin
				result = a & b;
				writesResult = 1'b0;
			end
			ALU_TEQ: begin
				result = a ^ b;
				writesResult = 1'b0;
			end
			ALU_ADD, ALU_SUB, ALU_RSB, ALU_CMP: begin
				result = addSum[MSB:0];
				isArith = 1'b1;
				isLogic = 1'b0;
				writesResult = (aluOp != ALU_CMP);
			end
			default: begin // ADC, SBC, RSC, CMN retire with no effect
				isLogic = 1'b0;
				writesResult = 1'b0;
			end
		endcase
	end

	always_comb begin
		flagsOut = flagsIn;
		if (isArith || isLogic)
			flagsOut[`FLAG_N -: 2] = {result[MSB], result == '0};
		if (isArith) begin
			flagsOut[`FLAG_C] = carry;
			flagsOut[`FLAG_V] = overflow;
		end
	end

endmodule

// ==== opQueue.sv ====
/*
	Operation queue between decoder and executor.
	Circular buffer of QUEUE_DEPTH decoded operations. push is taken only
	when full is low and pop only when empty is low; both may happen in
	the same cycle. Head fields are valid whenever empty is low.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module opQueue import armCtl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       push,
	input  opKind_e                    opKind,
	input  cond_e                      opCond,
	input  aluOp_e                     opAlu,
	input  logic                       opSetFlags,
	input  logic [`REG_ADDR_WIDTH-1:0] opRd,
	input  logic [`REG_ADDR_WIDTH-1:0] opRn,
	input  logic [`REG_ADDR_WIDTH-1:0] opRm,
	input  logic                       opImmValid,
	input  logic [`DATA_WIDTH-1:0]     opImm,
	input  logic                       opLink,
	input  logic [`DATA_WIDTH-1:0]     opTarget,
	input  logic [`DATA_WIDTH-1:0]     opPc,
	output logic                       full,
	input  logic                       pop,
	output logic                       empty,
	output opKind_e                    opKindHead,
	output cond_e                      opCondHead,
	output aluOp_e                     opAluHead,
	output logic                       opSetFlagsHead,
	output logic [`REG_ADDR_WIDTH-1:0] opRdHead,
	output logic [`REG_ADDR_WIDTH-1:0] opRnHead,
	output logic [`REG_ADDR_WIDTH-1:0] opRmHead,
	output logic                       opImmValidHead,
	output logic [`DATA_WIDTH-1:0]     opImmHead,
	output logic                       opLinkHead,
	output logic [`DATA_WIDTH-1:0]     opTargetHead,
	output logic [`DATA_WIDTH-1:0]     opPcHead
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`QUEUE_DEPTH - 1);

	typedef struct packed {
		opKind_e kind;
		cond_e cond;
		aluOp_e alu;
		logic setFlags;
		logic [`REG_ADDR_WIDTH-1:0] rd, rn, rm;
		logic immValid;
		logic [`DATA_WIDTH-1:0] imm;
		logic link;
		logic [`DATA_WIDTH-1:0] target, pc;
	} queueEntry_t;

	queueEntry_t entries [`QUEUE_DEPTH];
	queueEntry_t head;
	logic [PTR_W-1:0] wrPtr, rdPtr;
	logic [PTR_W:0] count;
	logic doPush, doPop;

	assign full = (count == (PTR_W + 1)'(`QUEUE_DEPTH));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign head = entries[rdPtr];
	assign opKindHead = head.kind;
	assign opCondHead = head.cond;
	assign opAluHead = head.alu;
	assign opSetFlagsHead = head.setFlags;
	assign opRdHead = head.rd;
	assign opRnHead = head.rn;
	assign opRmHead = head.rm;
	assign opImmValidHead = head.immValid;
	assign opImmHead = head.imm;
	assign opLinkHead = head.link;
	assign opTargetHead = head.target;
	assign opPcHead = head.pc;

	always_ff @(posedge clk) begin
		if (doPush)
			entries[wrPtr] <= '{opKind, opCond, opAlu, opSetFlags, opRd, opRn, opRm,
				opImmValid, opImm, opLink, opTarget, opPc};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

endmodule

// ==== instrDecoder.sv ====
/*
	Instruction receiver and decoder.
	Takes one ARM word per four-phase req/ack transfer, splits its fields,
	expands the rotated immediate and the branch target, and pushes the
	result into the operation queue. The ack is withheld while the queue
	is full, which stalls the sender.
*/
`include "armCtl_consts.svh"
`timescale 1ns/1ns

module instrDecoder import armCtl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instrReq,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic [`DATA_WIDTH-1:0]     instrPc,
	output logic                       instrAck,
	input  logic                       full,
	output logic                       push,
	output opKind_e                    opKind,
	output cond_e                      opCond,
	output aluOp_e                     opAlu,
	output logic                       opSetFlags,
	output logic [`REG_ADDR_WIDTH-1:0] opRd,
	output logic [`REG_ADDR_WIDTH-1:0] opRn,
	output logic [`REG_ADDR_WIDTH-1:0] opRm,
	output logic                       opImmValid,
	output logic [`DATA_WIDTH-1:0]     opImm,
	output logic                       opLink,
	output logic [`DATA_WIDTH-1:0]     opTarget,
	output logic [`DATA_WIDTH-1:0]     opPc
);

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_PUSH,
		DEC_ACK,
		DEC_RELEASE
	} decState_e;

	decState_e state, stateNext;
	logic [4:0] immRot;
	logic [2*`DATA_WIDTH-1:0] immPair;
	logic [`DATA_WIDTH-1:0] branchOffset;

	assign push = (state == DEC_PUSH) && !full;
	assign instrAck = (state == DEC_ACK);

	always_comb begin
		stateNext = state;
		case (state)
			DEC_IDLE:    if (instrReq) stateNext = DEC_PUSH;
			DEC_PUSH:    if (!full) stateNext = DEC_ACK; // hold here on back-pressure
			DEC_ACK:     if (!instrReq) stateNext = DEC_RELEASE;
			DEC_RELEASE: stateNext = DEC_IDLE; // ack is low, sender may raise req again
			default:     stateNext = DEC_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= DEC_IDLE;
		else
			state <= stateNext;
	end

	// sender holds instr and instrPc stable while req is high
	always_comb begin
		opCond = cond_e'(instr[31:28]);
		opAlu = aluOp_e'(instr[24:21]);
		opSetFlags = instr[20];
		opRn = instr[19:16];
		opRd = instr[15:12];
		opRm = instr[3:0];
		opImmValid = instr[25];

		// imm8 rotated right by twice the 4-bit rotate field
		immRot = {instr[11:8], 1'b0};
		immPair = {2{{24'b0, instr[7:0]}}} >> immRot;
		opImm = immPair[`DATA_WIDTH-1:0];

		opLink = instr[24];
		branchOffset = {{6{instr[23]}}, instr[23:0], 2'b00};
		opTarget = instrPc + `DATA_WIDTH'(8) + branchOffset; // pipeline pc is two words ahead
		opPc = instrPc;

		// register-shifted operands share encodings with multiply, so both drop to NOP
		if (instr[27:26] == 2'b00 && !(!instr[25] && instr[4]))
			opKind = DATA_PROC;
		else if (instr[27:25] == 3'b101)
			opKind = BRANCH;
		else
			opKind = NOP;
	end

endmodule

// ==== armCtl_pkg.sv ====
/*
	Enum types shared by the decoder, operation queue, executor and ALU.
	Import with a wildcard in the module header.
*/
package armCtl_pkg;

	// data-processing opcodes, ARM bits [24:21]
	typedef enum logic [3:0] {
		ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
		ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
		ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
	} aluOp_e;

	// condition field, ARM bits [31:28]
	typedef enum logic [3:0] {
		COND_EQ = 4'b0000, COND_NE = 4'b0001,
		COND_CS = 4'b0010, COND_CC = 4'b0011,
		COND_MI = 4'b0100, COND_PL = 4'b0101,
		COND_VS = 4'b0110, COND_VC = 4'b0111,
		COND_HI = 4'b1000, COND_LS = 4'b1001,
		COND_GE = 4'b1010, COND_LT = 4'b1011,
		COND_GT = 4'b1100, COND_LE = 4'b1101,
		COND_AL = 4'b1110,
		COND_NV = 4'b1111 // executed as always
	} cond_e;

	typedef enum logic [1:0] {
		DATA_PROC,
		BRANCH,
		NOP // load/store and unsupported classes
	} opKind_e;

endpackage

// ==== armCtl_consts.svh ====
/*
	Widths and sizes shared by the execute-control core.
	Include this file in any module that sizes its ports from it.
	Flag bit positions follow the NZCV order of the flags output.
*/
`ifndef ARMCTL_CONSTS_SVH
`define ARMCTL_CONSTS_SVH

`define DATA_WIDTH      32 // register and datapath width
`define REG_ADDR_WIDTH  4
`define REG_COUNT       16
`define LINK_REG        14 // BL return address goes here
`define QUEUE_DEPTH     4  // decoded ops waiting for the executor

// NZCV packing, N in the top bit
`define FLAG_WIDTH      4
`define FLAG_N          3
`define FLAG_Z          2
`define FLAG_C          1
`define FLAG_V          0

`endif
